//--- verilog/dup_params.svh
/*
 * DUP11 serial line unit parameters
 * Widths, bit timing, interrupt vectors and register addresses
 */

`ifndef DUP_PARAMS_SVH
`define DUP_PARAMS_SVH

// Bus data and serial character width
`define DUP_DATA_WIDTH  8

// Clocks per serial bit
`define DUP_BIT_CLKS    8

// Interrupt vectors (octal, as on the real unit)
`define DUP_VECT_WIDTH  9
`define DUP_RX_VECT     9'o300
`define DUP_TX_VECT     9'o304

// Register addresses
`define DUP_ADDR_WIDTH  2
`define DUP_ADDR_RXCSR  2'd0
`define DUP_ADDR_RXDBUF 2'd1
`define DUP_ADDR_TXCSR  2'd2
`define DUP_ADDR_TXDBUF 2'd3

`endif

//--- verilog/dupPkg.sv
/*
 * DUP11 shared types
 * Interrupt controller states, register selects and CSR bit positions
 */

`default_nettype none

`include "dup_params.svh"

package dupPkg;

   ////////////////////////////////////////////////////////////
   // Interrupt controller states
   ////////////////////////////////////////////////////////////

   typedef enum logic [2:0] {
      IDLE     = 3'd0,   // Waiting for a trigger
      ACTIVE   = 3'd1,   // Request up, waiting for vector read
      VECTREAD = 3'd2,   // Vector taken, waiting for ack release
      WAIT     = 3'd3,   // Waiting for a status access
      DONE     = 3'd4    // Waiting for the access to end
   } intrState_t;

   ////////////////////////////////////////////////////////////
   // Register selects
   ////////////////////////////////////////////////////////////

   typedef enum logic [`DUP_ADDR_WIDTH-1:0] {
      RXCSR  = `DUP_ADDR_RXCSR,
      RXDBUF = `DUP_ADDR_RXDBUF,
      TXCSR  = `DUP_ADDR_TXCSR,
      TXDBUF = `DUP_ADDR_TXDBUF
   } regSel_t;

   // CSR bit positions
   localparam int CSR_DONE = 7;
   localparam int CSR_IE   = 6;
   localparam int CSR_BUSY = 5;   // TXCSR only
   localparam int CSR_LOOP = 2;   // RXCSR only

endpackage

`default_nettype wire

//--- verilog/dupIntrIf.sv
/*
 * DUP11 interrupt controller bundle
 * Trigger and status strobes in, request and active status out
 */

`default_nettype none

interface dupIntrIf;

   // Set by the register block
   logic trig;     // One-clock trigger pulse
   logic statrw;   // Status register access in progress

   // Set by the top level
   logic vect;     // Interrupt vector read (bus ack)
   logic secinh;   // Secondary inhibit from higher priority

   // Set by the controller
   logic priact;   // Controller busy
   logic intr;     // Interrupt request

   // Register block side
   modport ctrl (
      output trig,
      output statrw,
      input  priact,
      input  intr
   );

   // Controller FSM side
   modport intrSm (
      input  trig,
      input  statrw,
      input  vect,
      input  secinh,
      output priact,
      output intr
   );

endinterface

`default_nettype wire

//--- verilog/dupSerialIf.sv
/*
 * DUP11 register to serial engine bundle
 * Transmit byte and load strobe, receive byte and done event
 */

`default_nettype none

`include "dup_params.svh"

interface dupSerialIf;

   // Transmit path
   logic [`DUP_DATA_WIDTH-1:0] txData;   // Byte to send
   logic                       txLoad;   // Start a frame, one clock
   logic                       txBusy;   // Frame in progress

   // Receive path
   logic [`DUP_DATA_WIDTH-1:0] rxData;   // Last byte received
   logic                       rxDone;   // Byte ready, one clock

   // Loopback enable level
   logic                       loop;

   modport regs (
      output txData,
      output txLoad,
      output loop,
      input  txBusy,
      input  rxData,
      input  rxDone
   );

   modport serial (
      input  txData,
      input  txLoad,
      input  loop,
      output txBusy,
      output rxData,
      output rxDone
   );

endinterface

`default_nettype wire

//--- verilog/dupIntr.sv
/*
 * DUP11 interrupt controller
 * Raises a request on trigger and drops it once the vector is read
 * Rearms only after a status register access has come and gone
 */

`default_nettype none

module dupIntr (
   input logic     clk,
   input logic     reset,
   input logic     init,
   dupIntrIf.intrSm bus
);

   dupPkg::intrState_t state;

   ////////////////////////////////////////////////////////////
   // Controller FSM
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset | init)
         state <= dupPkg::IDLE;
      else
      begin
         case (state)
            // Armed and waiting for a done event
            dupPkg::IDLE:
               if (bus.trig)
                  state <= dupPkg::ACTIVE;
            // Request up until the host takes the vector
            // A higher priority request holds us here
            dupPkg::ACTIVE:
               if (bus.vect && !bus.secinh)
                  state <= dupPkg::VECTREAD;
            // Vector taken and waiting for ack to drop
            dupPkg::VECTREAD:
               if (!bus.vect)
                  state <= dupPkg::WAIT;
            // Wait for the CSR to be touched
            dupPkg::WAIT:
               if (bus.statrw)
                  state <= dupPkg::DONE;
            // Rearm once the CSR access ends
            dupPkg::DONE:
               if (!bus.statrw)
                  state <= dupPkg::IDLE;
            default:
               state <= dupPkg::IDLE;
         endcase
      end
   end

   // Request drops the cycle after the vector read is taken
   assign bus.intr = (state == dupPkg::ACTIVE);

   // Busy anywhere outside IDLE so lower priority waits
   assign bus.priact = (state != dupPkg::IDLE);

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   // Trigger is a single clock pulse
   assert property (@(posedge clk) disable iff (reset || init)
      bus.trig |=> !bus.trig);

   // Host holds ack for at least two cycles
   assert property (@(posedge clk) disable iff (reset || init)
      $rose(bus.vect) |=> bus.vect);

endmodule

`default_nettype wire

//--- verilog/dupRegs.sv
/*
 * DUP11 register block
 * Bus decode, CSRs and receive buffer, read mux, interrupt
 * triggers and vector select
 */

`default_nettype none

`include "dup_params.svh"

module dupRegs (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        init,
   input  logic [`DUP_ADDR_WIDTH-1:0]  addr,
   input  logic                        wr,
   input  logic                        rd,
   input  logic [`DUP_DATA_WIDTH-1:0]  wrData,
   output logic [`DUP_DATA_WIDTH-1:0]  rdData,
   output logic                        rdValid,
   output logic [`DUP_VECT_WIDTH-1:0]  vector,
   dupIntrIf.ctrl                      rxIntr,
   dupIntrIf.ctrl                      txIntr,
   dupSerialIf.regs                    ser
);

   dupPkg::regSel_t            sel;
   logic                       rxIe;
   logic                       txIe;
   logic                       loopEn;
   logic                       rxDoneBit;
   logic                       txDoneBit;
   logic                       rxDoneQ;
   logic                       txDoneQ;
   logic                       txBusyQ;
   logic                       txAccept;
   logic                       txEnd;
   logic [`DUP_DATA_WIDTH-1:0] rxBuf;
   logic [`DUP_DATA_WIDTH-1:0] rdMux;

   ////////////////////////////////////////////////////////////
   // Bus decode
   ////////////////////////////////////////////////////////////

   assign sel = dupPkg::regSel_t'(addr);

   // CSR touched this cycle, read or write
   assign rxIntr.statrw = (rd | wr) && (sel == dupPkg::RXCSR);
   assign txIntr.statrw = (rd | wr) && (sel == dupPkg::TXCSR);

   // Buffer write starts a frame unless one is running
   assign txAccept   = wr && (sel == dupPkg::TXDBUF) && !ser.txBusy;
   assign ser.txLoad = txAccept;
   assign ser.txData = wrData;
   assign ser.loop   = loopEn;

   // Frame end seen as busy falling
   assign txEnd = txBusyQ && !ser.txBusy;

   ////////////////////////////////////////////////////////////
   // Control registers
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset | init)
      begin
         rxIe        <= 1'b0;
         txIe        <= 1'b0;
         loopEn      <= 1'b0;
         rxDoneBit   <= 1'b0;
         txDoneBit   <= 1'b0;
         rxDoneQ     <= 1'b0;
         txDoneQ     <= 1'b0;
         txBusyQ     <= 1'b0;
         rxIntr.trig <= 1'b0;
         txIntr.trig <= 1'b0;
         rdValid     <= 1'b0;
      end
      else
      begin
         // Writable CSR bits
         if (wr && (sel == dupPkg::RXCSR))
         begin
            rxIe   <= wrData[dupPkg::CSR_IE];
            loopEn <= wrData[dupPkg::CSR_LOOP];
         end
         if (wr && (sel == dupPkg::TXCSR))
            txIe <= wrData[dupPkg::CSR_IE];
         // Done flags, a new event wins over a clear
         if (ser.rxDone)
            rxDoneBit <= 1'b1;
         else if (rd && (sel == dupPkg::RXCSR))
            rxDoneBit <= 1'b0;
         if (txEnd)
            txDoneBit <= 1'b1;
         else if ((rd && (sel == dupPkg::TXCSR)) || txAccept)
            txDoneBit <= 1'b0;
         // Rising done with IE set fires a trigger
         rxDoneQ     <= rxDoneBit;
         txDoneQ     <= txDoneBit;
         txBusyQ     <= ser.txBusy;
         rxIntr.trig <= rxDoneBit && !rxDoneQ && rxIe;
         txIntr.trig <= txDoneBit && !txDoneQ && txIe;
         rdValid     <= rd;
      end
   end

   // Receive buffer, overwritten by every new byte
   always_ff @(posedge clk)
   begin
      if (ser.rxDone)
         rxBuf <= ser.rxData;
   end

   ////////////////////////////////////////////////////////////
   // Read path
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      rdMux = '0;
      case (sel)
         dupPkg::RXCSR:
         begin
            rdMux[dupPkg::CSR_DONE] = rxDoneBit;
            rdMux[dupPkg::CSR_IE]   = rxIe;
            rdMux[dupPkg::CSR_LOOP] = loopEn;
         end
         dupPkg::RXDBUF:
            rdMux = rxBuf;
         dupPkg::TXCSR:
         begin
            rdMux[dupPkg::CSR_DONE] = txDoneBit;
            rdMux[dupPkg::CSR_IE]   = txIe;
            rdMux[dupPkg::CSR_BUSY] = ser.txBusy;
         end
         // Transmit buffer is write only
         default:
            rdMux = '0;
      endcase
   end

   // Data lands one cycle after rd, sampled before any done clear
   always_ff @(posedge clk)
   begin
      if (rd)
         rdData <= rdMux;
   end

   // Receive wins while its controller is busy
   assign vector = rxIntr.priact ? `DUP_RX_VECT : `DUP_TX_VECT;

   // Host strobes are exclusive
   assert property (@(posedge clk) disable iff (reset)
      !(wr && rd));

endmodule

`default_nettype wire

//--- verilog/dupSerial.sv
/*
 * DUP11 serial engine
 * Ten-bit frame transmitter and mid-bit sampling receiver
 * Loopback feeds the transmit line into the receiver
 */

`default_nettype none

`include "dup_params.svh"

module dupSerial (
   input  logic       clk,
   input  logic       reset,
   input  logic       init,
   input  logic       rxd,
   output logic       txd,
   dupSerialIf.serial ser
);

   // Bit-time counter width, shared by both directions
   localparam int CW         = $clog2(`DUP_BIT_CLKS);
   localparam int FRAME_BITS = `DUP_DATA_WIDTH + 2;
   localparam logic [CW-1:0] BIT_LAST = CW'(`DUP_BIT_CLKS - 1);
   localparam logic [CW-1:0] BIT_HALF = CW'(`DUP_BIT_CLKS / 2 - 1);

   logic [FRAME_BITS-1:0]      txShift;
   logic [3:0]                 txBits;
   logic [CW-1:0]              txCnt;
   logic                       txBusy;
   logic                       rxIn;
   logic [2:0]                 rxSync;
   logic                       rxBit;
   logic                       rxFall;
   logic                       rxActive;
   logic [3:0]                 rxBits;
   logic [CW-1:0]              rxCnt;
   logic                       rxSample;
   logic                       rxDoneR;
   logic [`DUP_DATA_WIDTH-1:0] rxShift;

   ////////////////////////////////////////////////////////////
   // Transmitter
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset | init)
      begin
         // Line idles high
         txShift <= '1;
         txBits  <= '0;
         txCnt   <= '0;
         txBusy  <= 1'b0;
      end
      else if (ser.txLoad && !txBusy)
      begin
         // Stop, data LSB first, start
         txShift <= {1'b1, ser.txData, 1'b0};
         txBits  <= '0;
         txCnt   <= '0;
         txBusy  <= 1'b1;
      end
      else if (txBusy)
      begin
         if (txCnt == BIT_LAST)
         begin
            txCnt   <= '0;
            txShift <= {1'b1, txShift[FRAME_BITS-1:1]};
            // Last bit time of the stop bit ends the frame
            if (txBits == 4'(FRAME_BITS - 1))
               txBusy <= 1'b0;
            else
               txBits <= txBits + 4'd1;
         end
         else
            txCnt <= txCnt + 1'b1;
      end
   end

   assign txd        = txShift[0];
   assign ser.txBusy = txBusy;

   ////////////////////////////////////////////////////////////
   // Receiver
   ////////////////////////////////////////////////////////////

   assign rxIn     = ser.loop ? txd : rxd;
   assign rxBit    = rxSync[1];
   assign rxFall   = rxSync[2] && !rxSync[1];
   assign rxSample = rxActive && (rxCnt == '0);

   always_ff @(posedge clk)
   begin
      if (reset | init)
      begin
         rxSync   <= '1;
         rxActive <= 1'b0;
         rxBits   <= '0;
         rxCnt    <= '0;
         rxDoneR  <= 1'b0;
      end
      else
      begin
         rxSync  <= {rxSync[1:0], rxIn};
         rxDoneR <= 1'b0;
         if (!rxActive)
         begin
            // Start edge, aim for the middle of the start bit
            if (rxFall)
            begin
               rxActive <= 1'b1;
               rxBits   <= '0;
               rxCnt    <= BIT_HALF;
            end
         end
         else if (!rxSample)
            rxCnt <= rxCnt - 1'b1;
         else
         begin
            rxCnt  <= BIT_LAST;
            rxBits <= rxBits + 4'd1;
            // Glitch, start bit not low at its middle
            if ((rxBits == '0) && rxBit)
               rxActive <= 1'b0;
            // Stop bit must be high
            if (rxBits == 4'(FRAME_BITS - 1))
            begin
               rxActive <= 1'b0;
               rxDoneR  <= rxBit;
            end
         end
      end
   end

   // Data bits shift in from the top, LSB first
   always_ff @(posedge clk)
   begin
      if (rxSample && (rxBits != '0) && (rxBits != 4'(FRAME_BITS - 1)))
         rxShift <= {rxBit, rxShift[`DUP_DATA_WIDTH-1:1]};
   end

   assign ser.rxData = rxShift;
   assign ser.rxDone = rxDoneR;

endmodule

`default_nettype wire

//--- verilog/dupTop.sv
/*
 * DUP11 serial line unit
 * Registers, serial engine and receive and transmit
 * interrupt controllers, receive at higher priority
 */

`default_nettype none

`include "dup_params.svh"

module dupTop (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       init,
   input  logic [`DUP_ADDR_WIDTH-1:0] addr,
   input  logic                       wr,
   input  logic                       rd,
   input  logic [`DUP_DATA_WIDTH-1:0] wrData,
   input  logic                       ack,
   input  logic                       rxd,
   output logic [`DUP_DATA_WIDTH-1:0] rdData,
   output logic                       rdValid,
   output logic                       intr,
   output logic [`DUP_VECT_WIDTH-1:0] vector,
   output logic                       txd
);

   dupIntrIf   rxIntrBus ();
   dupIntrIf   txIntrBus ();
   dupSerialIf serBus ();

   // Ack doubles as the vector read for both controllers
   assign rxIntrBus.vect   = ack;
   assign txIntrBus.vect   = ack;

   // Receive is never inhibited, transmit waits on receive
   assign rxIntrBus.secinh = 1'b0;
   assign txIntrBus.secinh = rxIntrBus.priact;

   assign intr = rxIntrBus.intr | txIntrBus.intr;

   dupRegs u_regs (
      .clk     (clk),
      .reset   (reset),
      .init    (init),
      .addr    (addr),
      .wr      (wr),
      .rd      (rd),
      .wrData  (wrData),
      .rdData  (rdData),
      .rdValid (rdValid),
      .vector  (vector),
      .rxIntr  (rxIntrBus),
      .txIntr  (txIntrBus),
      .ser     (serBus)
   );

   dupSerial u_serial (
      .clk   (clk),
      .reset (reset),
      .init  (init),
      .rxd   (rxd),
      .txd   (txd),
      .ser   (serBus)
   );

   dupIntr u_rxIntr (
      .clk   (clk),
      .reset (reset),
      .init  (init),
      .bus   (rxIntrBus)
   );

   dupIntr u_txIntr (
      .clk   (clk),
      .reset (reset),
      .init  (init),
      .bus   (txIntrBus)
   );

endmodule

`default_nettype wire

//--- test/dupChecker.sv
/*
 * DUP11 testbench checker
 * Decodes txd frames bit by bit and compares bus reads, the
 * interrupt vector and intr against values posted by the testbench
 */

`default_nettype none

`include "dup_params.svh"

module dupChecker (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       txd,
   input  logic                       rdValid,
   input  logic [`DUP_DATA_WIDTH-1:0] rdData,
   input  logic                       intr,
   input  logic [`DUP_VECT_WIDTH-1:0] vector,
   input  logic [8*12-1:0]            testName,
   input  logic [`DUP_DATA_WIDTH+1:0] expTx,
   input  logic                       chkEn,
   input  logic [1:0]                 chkSel,
   input  logic [`DUP_VECT_WIDTH-1:0] expVal,
   output int                         framesSeen,
   output int                         checks,
   output int                         errors
);

   localparam int FRAME_CLKS = (`DUP_DATA_WIDTH + 2) * `DUP_BIT_CLKS;
   localparam logic [1:0] SEL_RD   = 2'd0;
   localparam logic [1:0] SEL_VECT = 2'd1;

   logic                       chkEnQ;
   logic [1:0]                 chkSelQ;
   logic [`DUP_VECT_WIDTH-1:0] expQ;
   logic [`DUP_VECT_WIDTH-1:0] act;
   int                         chkErrors;
   int                         frameErrors;
   logic                       inFrame;
   logic                       edgeBad;
   int                         sampleNum;
   logic [`DUP_DATA_WIDTH+1:0] gotFrame;

   assign errors = chkErrors + frameErrors;

   function automatic string checkName(input logic [1:0] sel);
      case (sel)
         SEL_RD:   return "read data";
         SEL_VECT: return "vector";
         default:  return "intr";
      endcase
   endfunction

   ////////////////////////////////////////////////////////////
   // Output checks
   ////////////////////////////////////////////////////////////

   // Request posted on a falling edge, taken here
   always @(posedge clk)
   begin
      chkEnQ  <= chkEn;
      chkSelQ <= chkSel;
      expQ    <= expVal;
   end

   // Compared one cycle later, outputs settled
   always @(negedge clk)
   begin
      if (reset)
      begin
         chkErrors <= 0;
         checks    <= 0;
      end
      else if (chkEnQ === 1'b1)
      begin
         checks <= checks + 1;
         case (chkSelQ)
            SEL_RD:   act = rdData;
            SEL_VECT: act = vector;
            default:  act = intr;
         endcase
         if ((chkSelQ == SEL_RD) && (rdValid !== 1'b1))
         begin
            $display("%0s: rdValid was not high one cycle after rd", testName);
            chkErrors <= chkErrors + 1;
         end
         else if (act !== expQ)
         begin
            $display("[ERROR] %0s %0s: expected %h, actual %h",
                     testName, checkName(chkSelQ), expQ, act);
            chkErrors <= chkErrors + 1;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Frame decoder
   ////////////////////////////////////////////////////////////

   always @(negedge clk)
   begin
      if (reset)
      begin
         inFrame     = 1'b0;
         sampleNum   = 0;
         framesSeen  <= 0;
         frameErrors <= 0;
      end
      else if (inFrame || (txd === 1'b0))
      begin
         // Start edge
         if (!inFrame)
         begin
            inFrame   = 1'b1;
            sampleNum = 0;
            edgeBad   = 1'b0;
            gotFrame  = '1;
         end
         // Every clock of a bit must show that bit
         if (txd !== expTx[sampleNum / `DUP_BIT_CLKS])
            edgeBad = 1'b1;
         // Mid-bit sample
         if ((sampleNum % `DUP_BIT_CLKS) == (`DUP_BIT_CLKS / 2))
            gotFrame[sampleNum / `DUP_BIT_CLKS] = txd;
         sampleNum = sampleNum + 1;
         if (sampleNum == FRAME_CLKS)
         begin
            inFrame = 1'b0;
            framesSeen <= framesSeen + 1;
            if (gotFrame !== expTx)
            begin
               $display("[ERROR] %0s txd frame: expected %h, actual %h",
                        testName, expTx, gotFrame);
               frameErrors <= frameErrors + 1;
            end
            else if (edgeBad)
            begin
               $display("%0s: txd bits did not last exactly %0d clocks each",
                        testName, `DUP_BIT_CLKS);
               frameErrors <= frameErrors + 1;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- test/dupTb.sv
/*
 * DUP11 serial line unit testbench
 * Bus tasks, random transmit bytes and the expected frame model
 * Outputs are compared by dupChecker
 */

`default_nettype none

`include "dup_params.svh"

module dupTb;

   localparam int TIMEOUT_CYCLES = 6 * 4 * 10 * `DUP_BIT_CLKS + 2000;
   localparam int FRAME_LIMIT    = 20 * `DUP_BIT_CLKS;
   localparam int INTR_LIMIT     = 4 * `DUP_BIT_CLKS;

   // CSR bits
   localparam logic [7:0] DONE = 8'h80;
   localparam logic [7:0] IE   = 8'h40;
   localparam logic [7:0] BUSY = 8'h20;
   localparam logic [7:0] LOOP = 8'h04;

   // What the checker compares
   localparam logic [1:0] SEL_RD   = 2'd0;
   localparam logic [1:0] SEL_VECT = 2'd1;
   localparam logic [1:0] SEL_INTR = 2'd2;

   logic                       clk;
   logic                       reset;
   logic                       init;
   logic [`DUP_ADDR_WIDTH-1:0] addr;
   logic                       wr;
   logic                       rd;
   logic [`DUP_DATA_WIDTH-1:0] wrData;
   logic                       ack;
   logic                       rxd;
   logic [`DUP_DATA_WIDTH-1:0] rdData;
   logic                       rdValid;
   logic                       intr;
   logic [`DUP_VECT_WIDTH-1:0] vector;
   logic                       txd;
   logic [8*12-1:0]            testName;
   logic [`DUP_DATA_WIDTH+1:0] expTx;
   logic                       chkEn;
   logic [1:0]                 chkSel;
   logic [`DUP_VECT_WIDTH-1:0] expVal;
   int                         framesSeen;
   int                         checks;
   int                         errors;
   int                         tbErrors;
   int                         errBase;
   int                         testsRun;
   int                         testsFailed;
   int                         seed;
   int                         cycles = 0;
   logic [`DUP_DATA_WIDTH-1:0] b;

   initial clk = 1'b0;
   always #20 clk = ~clk;

   dupTop u_dupTop (
      .clk     (clk),
      .reset   (reset),
      .init    (init),
      .addr    (addr),
      .wr      (wr),
      .rd      (rd),
      .wrData  (wrData),
      .ack     (ack),
      .rxd     (rxd),
      .rdData  (rdData),
      .rdValid (rdValid),
      .intr    (intr),
      .vector  (vector),
      .txd     (txd)
   );

   dupChecker u_checker (
      .clk        (clk),
      .reset      (reset),
      .txd        (txd),
      .rdValid    (rdValid),
      .rdData     (rdData),
      .intr       (intr),
      .vector     (vector),
      .testName   (testName),
      .expTx      (expTx),
      .chkEn      (chkEn),
      .chkSel     (chkSel),
      .expVal     (expVal),
      .framesSeen (framesSeen),
      .checks     (checks),
      .errors     (errors)
   );

   // Start bit, data LSB first, stop bit
   function automatic logic [`DUP_DATA_WIDTH+1:0] expFrame(input logic [7:0] data);
      logic [`DUP_DATA_WIDTH+1:0] f;
      f[0] = 1'b0;
      for (int i = 0; i < `DUP_DATA_WIDTH; i++)
         f[i + 1] = data[i];
      f[`DUP_DATA_WIDTH + 1] = 1'b1;
      return f;
   endfunction

   ////////////////////////////////////////////////////////////
   // Bus and check tasks, all entered on a falling edge
   ////////////////////////////////////////////////////////////

   task automatic busWrite(input logic [1:0] a, input logic [7:0] d);
      addr   = a;
      wrData = d;
      wr     = 1'b1;
      @(negedge clk);
      wr = 1'b0;
   endtask

   task automatic busRead(input logic [1:0] a, output logic [7:0] d);
      addr = a;
      rd   = 1'b1;
      @(negedge clk);
      rd = 1'b0;
      d  = rdData;
   endtask

   // Checker compares one cycle later
   task automatic checkOut(input logic [1:0] sel, input logic [8:0] exp);
      chkEn  = 1'b1;
      chkSel = sel;
      expVal = exp;
      @(negedge clk);
      chkEn = 1'b0;
   endtask

   task automatic readCheck(input logic [1:0] a, input logic [7:0] exp);
      addr = a;
      rd   = 1'b1;
      checkOut(SEL_RD, exp);
      rd = 1'b0;
   endtask

   task automatic pulseInit();
      init = 1'b1;
      @(negedge clk);
      init = 1'b0;
   endtask

   task automatic sendRandom(output logic [7:0] d);
      d     = $random(seed);
      expTx = expFrame(d);
      busWrite(`DUP_ADDR_TXDBUF, d);
   endtask

   task automatic waitFrame();
      int start;
      int n;
      start = framesSeen;
      n = 0;
      while ((framesSeen == start) && (n < FRAME_LIMIT))
      begin
         @(negedge clk);
         n++;
      end
      if (framesSeen == start)
      begin
         $display("%0s: no frame on txd within %0d cycles", testName, FRAME_LIMIT);
         tbErrors++;
      end
   endtask

   task automatic waitIntr();
      int n;
      n = 0;
      while ((intr !== 1'b1) && (n < INTR_LIMIT))
      begin
         @(negedge clk);
         n++;
      end
      if (intr !== 1'b1)
      begin
         $display("%0s: intr did not rise within %0d cycles", testName, INTR_LIMIT);
         tbErrors++;
      end
   endtask

   // Poll TXCSR until busy drops
   task automatic waitTxIdle();
      logic [7:0] stat;
      int n;
      stat = BUSY;
      n = 0;
      while (((stat & BUSY) != 0) && (n < FRAME_LIMIT))
      begin
         busRead(`DUP_ADDR_TXCSR, stat);
         n++;
      end
      if ((stat & BUSY) != 0)
      begin
         $display("%0s: transmitter still busy after %0d polls", testName, n);
         tbErrors++;
      end
   endtask

   // Vector check, then ack held two cycles
   task automatic takeVector(input logic [8:0] v, input logic intrAfter);
      checkOut(SEL_VECT, v);
      ack = 1'b1;
      checkOut(SEL_INTR, intrAfter);
      @(negedge clk);
      ack = 1'b0;
      @(negedge clk);
   endtask

   task automatic startTest(input logic [8*12-1:0] name);
      testName = name;
      errBase  = errors + tbErrors;
   endtask

   task automatic endTest();
      int failed;
      // Let the last comparison land
      @(negedge clk);
      failed = errors + tbErrors - errBase;
      testsRun++;
      if (failed == 0)
         $display("test %0s: ok", testName);
      else
      begin
         $display("test %0s: %0d error(s)", testName, failed);
         testsFailed++;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////

   initial
   begin
      reset    = 1'b1;
      init     = 1'b0;
      addr     = '0;
      wr       = 1'b0;
      rd       = 1'b0;
      wrData   = '0;
      ack      = 1'b0;
      rxd      = 1'b1;
      chkEn    = 1'b0;
      chkSel   = SEL_RD;
      expVal   = '0;
      expTx    = '1;
      testName = "reset";
      tbErrors    = 0;
      testsRun    = 0;
      testsFailed = 0;
      seed        = 5579;
      repeat (8) @(negedge clk);
      reset = 1'b0;

      // Read-only bits stay clear, init wipes the CSRs
      startTest("regAccess");
      readCheck(`DUP_ADDR_RXCSR, 8'h00);
      readCheck(`DUP_ADDR_TXCSR, 8'h00);
      busWrite(`DUP_ADDR_RXCSR, 8'hFF);
      readCheck(`DUP_ADDR_RXCSR, IE | LOOP);
      busWrite(`DUP_ADDR_TXCSR, 8'hFF);
      readCheck(`DUP_ADDR_TXCSR, IE);
      pulseInit();
      readCheck(`DUP_ADDR_RXCSR, 8'h00);
      readCheck(`DUP_ADDR_TXCSR, 8'h00);
      endTest();

      // Frames of random bytes, a write while busy is dropped
      startTest("txFrame");
      for (int i = 0; i < 4; i++)
      begin
         sendRandom(b);
         readCheck(`DUP_ADDR_TXCSR, BUSY);
         busWrite(`DUP_ADDR_TXDBUF, ~b);
         waitTxIdle();
         readCheck(`DUP_ADDR_TXCSR, DONE);
      end
      endTest();

      // Transmit line looped into the receiver
      startTest("loopback");
      busWrite(`DUP_ADDR_RXCSR, LOOP);
      sendRandom(b);
      waitFrame();
      repeat (4) @(negedge clk);
      readCheck(`DUP_ADDR_RXCSR, DONE | LOOP);
      readCheck(`DUP_ADDR_RXDBUF, b);
      readCheck(`DUP_ADDR_RXCSR, LOOP);
      endTest();

      // No retrigger until TXCSR has been touched
      startTest("txIntr");
      pulseInit();
      busWrite(`DUP_ADDR_TXCSR, IE);
      sendRandom(b);
      waitFrame();
      waitIntr();
      takeVector(`DUP_TX_VECT, 1'b0);
      sendRandom(b);
      waitFrame();
      repeat (8) @(negedge clk);
      checkOut(SEL_INTR, 1'b0);
      readCheck(`DUP_ADDR_TXCSR, DONE | IE);
      sendRandom(b);
      waitFrame();
      waitIntr();
      takeVector(`DUP_TX_VECT, 1'b0);
      endTest();

      // Receive served first, transmit after RXCSR access
      startTest("priority");
      pulseInit();
      busWrite(`DUP_ADDR_RXCSR, IE | LOOP);
      busWrite(`DUP_ADDR_TXCSR, IE);
      sendRandom(b);
      waitFrame();
      repeat (6) @(negedge clk);
      checkOut(SEL_INTR, 1'b1);
      takeVector(`DUP_RX_VECT, 1'b1);
      readCheck(`DUP_ADDR_RXCSR, DONE | IE | LOOP);
      takeVector(`DUP_TX_VECT, 1'b0);
      endTest();

      $display("tests %0d, failed %0d, checks %0d, frames %0d, errors %0d",
               testsRun, testsFailed, checks, framesSeen, errors + tbErrors);
      if ((testsFailed == 0) && (errors + tbErrors == 0))
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

   // Run limit
   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (cycles > TIMEOUT_CYCLES)
      begin
         $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
         $display("TESTS FAILED");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- flist.f
+incdir+verilog
verilog/dupPkg.sv
verilog/dupIntrIf.sv
verilog/dupSerialIf.sv
verilog/dupIntr.sv
verilog/dupRegs.sv
verilog/dupSerial.sv
verilog/dupTop.sv
test/dupChecker.sv
test/dupTb.sv
